/* source/sdCard_config.svh */
`ifndef SD_CARD_CONFIG_SVH
`define SD_CARD_CONFIG_SVH

// ======================================================================
// Card identity and response words
// ======================================================================

// Address handed out by CMD3
`define SD_RCA              16'hAAAA

// Low half of the R6 argument
`define SD_R6_STATUS        16'h0520

// R1 argument, transfer state and ready for data
`define SD_CARD_STATUS      32'h0000_0900

// R3 argument with the power-up done bit set
`define SD_OCR_READY        32'hC1FF_8080

// ======================================================================
// Timing and block geometry, in clock cycles
// ======================================================================

`define SD_NCR              2
`define SD_NAC              8
`define SD_BLOCK_NIBBLES    1024
`define SD_FIRST_WORD       16'hFFFF

`endif

/* source/sdCardPkg.sv */
package sdCardPkg;

    // Top bit set for application commands
    typedef logic [6:0] cmdIndexT;

    localparam cmdIndexT CMD0   = {1'b0, 6'd0};
    localparam cmdIndexT CMD3   = {1'b0, 6'd3};
    localparam cmdIndexT CMD7   = {1'b0, 6'd7};
    localparam cmdIndexT CMD8   = {1'b0, 6'd8};
    localparam cmdIndexT CMD12  = {1'b0, 6'd12};
    localparam cmdIndexT CMD18  = {1'b0, 6'd18};
    localparam cmdIndexT CMD55  = {1'b0, 6'd55};
    localparam cmdIndexT ACMD41 = {1'b1, 6'd41};

    // Received command, judged by the receiver
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic        frameOk;
    } cmdFrameT;

    // Response to send on the command line
    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic        noCrc;
    } respFrameT;

    typedef logic [6:0]  crc7T;
    typedef logic [15:0] crc16T;

    // Generator polynomials without the top term
    localparam crc7T  CRC7_POLY  = 7'h09;
    localparam crc16T CRC16_POLY = 16'h1021;

    typedef logic [15:0] readWordT;

endpackage

/* source/sdCrc.sv */
`timescale 1ns/1ps

module sdCrc #(
    parameter type crcT = logic [6:0],
    parameter crcT poly = '0
) (
    input  logic clk,
    input  logic rst_,
    input  logic clear,
    input  logic enable,
    input  logic din,
    output crcT  crc,
    output crcT  crcNext
);
    localparam int Width = $bits(crcT);

    logic feedback;

    // MSB-first shift, poly folded in when the feedback bit is set
    assign feedback = din ^ crc[Width-1];
    assign crcNext  = feedback ? crcT'((crc << 1) ^ poly) : crcT'(crc << 1);

    always_ff @(posedge clk) begin
        if (!rst_ || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= crcNext;
        end
    end

endmodule

/* source/sdPhaseTimer.sv */
`timescale 1ns/1ps

module sdPhaseTimer #(
    parameter int width = 8
) (
    input  logic             clk,
    input  logic             rst_,
    input  logic             load,
    input  logic [width-1:0] count,
    output logic             done
);
    logic [width-1:0] remain;
    logic             running;

    // done comes count cycles after the load cycle
    assign done = running && (remain == '0);

    always_ff @(posedge clk) begin
        if (!rst_) begin
            remain  <= '0;
            running <= 1'b0;
        end else if (load) begin
            remain  <= count - 1'b1;
            running <= (count != '0);
        end else if (running) begin
            if (remain == '0) begin
                running <= 1'b0;
            end else begin
                remain <= remain - 1'b1;
            end
        end
    end

endmodule

/* source/sdCmdReceiver.sv */
`timescale 1ns/1ps

module sdCmdReceiver (
    input  logic                 clk,
    input  logic                 rst_,
    input  logic                 cmdIn,
    input  logic                 cmdOe,
    output logic                 cmdValid,
    output sdCardPkg::cmdFrameT  cmdFrame
);
    import sdCardPkg::*;

    logic        receiving;
    logic [5:0]  bitCnt;
    logic [46:0] shiftReg;
    logic [47:0] frameBits;
    logic        startBit;
    logic        lastBit;
    logic        crcEnable;
    crc7T        crc;

    // Own output on the line is never taken as a start bit
    assign startBit  = !receiving && !cmdOe && !cmdIn;
    assign lastBit   = receiving && (bitCnt == 6'd47);
    assign crcEnable = startBit || (receiving && (bitCnt < 6'd40));
    assign frameBits = {shiftReg, cmdIn};

    sdCrc #(.crcT(crc7T), .poly(CRC7_POLY)) crc7 (
        .clk     (clk),
        .rst_    (rst_),
        .clear   (lastBit),
        .enable  (crcEnable),
        .din     (cmdIn),
        .crc     (crc),
        .crcNext ()
    );

    always_ff @(posedge clk) begin
        if (!rst_) begin
            receiving <= 1'b0;
            bitCnt    <= '0;
            cmdValid  <= 1'b0;
        end else begin
            cmdValid <= lastBit;
            if (startBit) begin
                receiving <= 1'b1;
                bitCnt    <= 6'd1;
            end else if (lastBit) begin
                receiving <= 1'b0;
            end else if (receiving) begin
                bitCnt <= bitCnt + 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        shiftReg <= frameBits[46:0];
        if (lastBit) begin
            cmdFrame.index   <= frameBits[45:40];
            cmdFrame.arg     <= frameBits[39:8];
            // Preamble 01, CRC match, end bit 1
            cmdFrame.frameOk <= (frameBits[47:46] == 2'b01) && (frameBits[7:1] == crc)
                                && frameBits[0];
        end
    end

endmodule

/* source/sdCardControl.sv */
`timescale 1ns/1ps
`include "sdCard_config.svh"

module sdCardControl (
    input  logic                  clk,
    input  logic                  rst_,
    input  logic                  cmdValid,
    input  sdCardPkg::cmdFrameT   cmdFrame,
    output logic                  respReq,
    output sdCardPkg::respFrameT  respFrame,
    output logic                  readStart,
    output logic                  readStop,
    output logic                  cmdError
);
    import sdCardPkg::*;

    typedef enum logic {Idle, Reading} stateT;

    stateT     state;
    logic      appPrefix;
    logic [15:0] rca;
    cmdIndexT  code;
    logic      respNext;
    logic      errorNext;
    logic      startNext;
    logic      stopNext;
    respFrameT frameNext;

    // ======================================================================
    // Command decode
    // ======================================================================
    always_comb begin
        // Only ACMD41 is defined after CMD55, anything else decodes as usual
        if (appPrefix && ({1'b1, cmdFrame.index} == ACMD41)) begin
            code = ACMD41;
        end else begin
            code = {1'b0, cmdFrame.index};
        end
        respNext  = 1'b0;
        errorNext = 1'b0;
        startNext = 1'b0;
        stopNext  = 1'b0;
        frameNext = '{index: cmdFrame.index, arg: `SD_CARD_STATUS, noCrc: 1'b0};
        if (cmdValid) begin
            if (!cmdFrame.frameOk) begin
                errorNext = 1'b1;
            end else begin
                case (code)
                    CMD0: stopNext = 1'b1;
                    CMD3: begin
                        respNext      = 1'b1;
                        frameNext.arg = {`SD_RCA, `SD_R6_STATUS};
                    end
                    CMD7: begin
                        respNext  = (cmdFrame.arg[31:16] == rca);
                        errorNext = (cmdFrame.arg[31:16] != rca);
                    end
                    CMD8: begin
                        // Echo voltage and check pattern
                        respNext      = 1'b1;
                        frameNext.arg = {20'h0, cmdFrame.arg[11:0]};
                    end
                    CMD12: begin
                        respNext = 1'b1;
                        stopNext = 1'b1;
                    end
                    CMD18: begin
                        respNext  = 1'b1;
                        startNext = 1'b1;
                    end
                    CMD55: respNext = 1'b1;
                    ACMD41: begin
                        respNext  = 1'b1;
                        frameNext = '{index: 6'h3F, arg: `SD_OCR_READY, noCrc: 1'b1};
                    end
                    default: errorNext = 1'b1;
                endcase
            end
        end
    end

    // ======================================================================
    // Card state and strobes
    // ======================================================================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state     <= Idle;
            appPrefix <= 1'b0;
            rca       <= '0;
            respReq   <= 1'b0;
            readStart <= 1'b0;
            readStop  <= 1'b0;
            cmdError  <= 1'b0;
        end else begin
            respReq   <= respNext;
            readStart <= startNext;
            readStop  <= stopNext && (state == Reading);
            cmdError  <= errorNext;
            if (cmdValid) begin
                appPrefix <= cmdFrame.frameOk && (code == CMD55);
                if (cmdFrame.frameOk && (code == CMD3)) begin
                    rca <= `SD_RCA;
                end else if (cmdFrame.frameOk && (code == CMD0)) begin
                    rca <= '0;
                end
            end
            if (startNext) begin
                state <= Reading;
            end else if (stopNext) begin
                state <= Idle;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respNext) begin
            respFrame <= frameNext;
        end
    end

endmodule

/* source/sdRespSender.sv */
`timescale 1ns/1ps
`include "sdCard_config.svh"

module sdRespSender (
    input  logic                  clk,
    input  logic                  rst_,
    input  logic                  respReq,
    input  sdCardPkg::respFrameT  respFrame,
    output logic                  cmdOut,
    output logic                  cmdOe
);
    import sdCardPkg::*;

    typedef enum logic [2:0] {Idle, Delay, Data, Crc, End} phaseT;

    phaseT       phase;
    logic [39:0] dataReg;
    logic        noCrc;
    crc7T        crcNext;
    crc7T        crcReg;
    logic        timerLoad;
    logic [5:0]  timerCount;
    logic        timerDone;

    sdPhaseTimer #(.width(6)) timer (
        .clk   (clk),
        .rst_  (rst_),
        .load  (timerLoad),
        .count (timerCount),
        .done  (timerDone)
    );

    // CRC7 over preamble, index and argument
    sdCrc #(.crcT(crc7T), .poly(CRC7_POLY)) crc7 (
        .clk     (clk),
        .rst_    (rst_),
        .clear   (phase == Idle),
        .enable  (phase == Data),
        .din     (dataReg[39]),
        .crc     (),
        .crcNext (crcNext)
    );

    always_comb begin
        timerLoad  = 1'b0;
        timerCount = 6'(`SD_NCR - 1);
        if ((phase == Idle) && respReq) begin
            timerLoad = 1'b1;
        end else if ((phase == Delay) && timerDone) begin
            timerLoad  = 1'b1;
            timerCount = 6'd40;
        end else if ((phase == Data) && timerDone) begin
            timerLoad  = 1'b1;
            timerCount = 6'd7;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_) begin
            phase <= Idle;
        end else begin
            case (phase)
                Idle:    if (respReq) phase <= Delay;
                Delay:   if (timerDone) phase <= Data;
                Data:    if (timerDone) phase <= Crc;
                Crc:     if (timerDone) phase <= End;
                default: phase <= Idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((phase == Idle) && respReq) begin
            dataReg <= {2'b00, respFrame.index, respFrame.arg};
            noCrc   <= respFrame.noCrc;
        end else if (phase == Data) begin
            dataReg <= dataReg << 1;
        end
        // Last data bit is folded in through crcNext
        if ((phase == Data) && timerDone) begin
            crcReg <= noCrc ? '1 : crcNext;
        end else if (phase == Crc) begin
            crcReg <= crcReg << 1;
        end
    end

    assign cmdOe = phase inside {Data, Crc, End};

    always_comb begin
        case (phase)
            Data:    cmdOut = dataReg[39];
            Crc:     cmdOut = crcReg[6];
            default: cmdOut = 1'b1;
        endcase
    end

endmodule

/* source/sdDatSender.sv */
`timescale 1ns/1ps
`include "sdCard_config.svh"

module sdDatSender (
    input  logic       clk,
    input  logic       rst_,
    input  logic       readStart,
    input  logic       readStop,
    output logic [3:0] datOut,
    output logic       datOe
);
    import sdCardPkg::*;

    typedef enum logic [2:0] {Idle, Gap, Start, Payload, Crc, End} phaseT;

    phaseT       phase;
    readWordT    readWord;
    logic [1:0]  nibSel;
    logic [3:0]  nibble;
    crc16T       crcNext [4];
    crc16T       crcShift [4];
    logic        timerLoad;
    logic [10:0] timerCount;
    logic        timerDone;

    // High nibble first
    assign nibble = 4'(readWord >> {~nibSel, 2'b00});

    sdPhaseTimer #(.width(11)) timer (
        .clk   (clk),
        .rst_  (rst_),
        .load  (timerLoad),
        .count (timerCount),
        .done  (timerDone)
    );

    for (genvar i = 0; i < 4; i++) begin : gLine
        sdCrc #(.crcT(crc16T), .poly(CRC16_POLY)) crc16 (
            .clk     (clk),
            .rst_    (rst_),
            .clear   (phase != Payload),
            .enable  (phase == Payload),
            .din     (nibble[i]),
            .crc     (),
            .crcNext (crcNext[i])
        );
    end

    // ======================================================================
    // Phase lengths
    // ======================================================================
    always_comb begin
        timerLoad  = 1'b0;
        timerCount = 11'(`SD_NAC);
        if (readStart) begin
            timerLoad  = 1'b1;
            timerCount = 11'(`SD_NAC - 1);
        end else if (phase == Start) begin
            timerLoad  = 1'b1;
            timerCount = 11'(`SD_BLOCK_NIBBLES);
        end else if ((phase == Payload) && timerDone) begin
            timerLoad  = 1'b1;
            timerCount = 11'd16;
        end else if (phase == End) begin
            timerLoad = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_ || readStop) begin
            phase <= Idle;
        end else if (readStart) begin
            phase <= Gap;
        end else begin
            case (phase)
                Gap:     if (timerDone) phase <= Start;
                Start:   phase <= Payload;
                Payload: if (timerDone) phase <= Crc;
                Crc:     if (timerDone) phase <= End;
                End:     phase <= Gap;
                default: phase <= Idle;
            endcase
        end
    end

    // Word count runs on across blocks
    always_ff @(posedge clk) begin
        if (readStart) begin
            readWord <= `SD_FIRST_WORD;
        end else if ((phase == Payload) && (nibSel == 2'd3)) begin
            readWord <= readWord - 1'b1;
        end
        nibSel <= (phase == Payload) ? nibSel + 2'd1 : 2'd0;
        for (int i = 0; i < 4; i++) begin
            if ((phase == Payload) && timerDone) begin
                crcShift[i] <= crcNext[i];
            end else if (phase == Crc) begin
                crcShift[i] <= crcShift[i] << 1;
            end
        end
    end

    assign datOe = phase inside {Start, Payload, Crc, End};

    always_comb begin
        case (phase)
            Start:   datOut = 4'h0;
            Payload: datOut = nibble;
            Crc:     datOut = {crcShift[3][15], crcShift[2][15], crcShift[1][15], crcShift[0][15]};
            default: datOut = 4'hF;
        endcase
    end

endmodule

/* source/sdCardTop.sv */
`timescale 1ns/1ps

module sdCardTop (
    input  logic       clk,
    input  logic       rst_,
    input  logic       cmdIn,
    output logic       cmdOut,
    output logic       cmdOe,
    output logic [3:0] datOut,
    output logic       datOe,
    output logic       cmdError
);
    import sdCardPkg::*;

    logic      cmdValid;
    cmdFrameT  cmdFrame;
    logic      respReq;
    respFrameT respFrame;
    logic      readStart;
    logic      readStop;

    sdCmdReceiver receiver (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdOe    (cmdOe),
        .cmdValid (cmdValid),
        .cmdFrame (cmdFrame)
    );

    sdCardControl control (
        .clk       (clk),
        .rst_      (rst_),
        .cmdValid  (cmdValid),
        .cmdFrame  (cmdFrame),
        .respReq   (respReq),
        .respFrame (respFrame),
        .readStart (readStart),
        .readStop  (readStop),
        .cmdError  (cmdError)
    );

    sdRespSender respSender (
        .clk       (clk),
        .rst_      (rst_),
        .respReq   (respReq),
        .respFrame (respFrame),
        .cmdOut    (cmdOut),
        .cmdOe     (cmdOe)
    );

    sdDatSender datSender (
        .clk       (clk),
        .rst_      (rst_),
        .readStart (readStart),
        .readStop  (readStop),
        .datOut    (datOut),
        .datOe     (datOe)
    );

endmodule

/* dv/sdCard_checker.sv */
`timescale 1ns/1ps

module sdCardChecker (
    input logic clk,
    input logic rst_,
    input logic cmdOut,
    input logic cmdOe,
    input logic datOe,
    input logic cmdError
);
    // Raised by any failing property below
    logic assertFailed = 1'b0;

    // ======================================================================
    // Bus drivers and strobes
    // ======================================================================

    // Both line drivers released while reset is applied
    resetQuiet: assert property (@(posedge clk) !rst_ |=> (!cmdOe && !datOe))
        else begin
            $error("cmdOe or datOe high after a reset cycle");
            assertFailed = 1'b1;
        end

    errorPulse: assert property (@(posedge clk) disable iff (!rst_) cmdError |=> !cmdError)
        else begin
            $error("cmdError held high for two cycles");
            assertFailed = 1'b1;
        end

    // A response always opens with its start bit
    startBitLow: assert property (@(posedge clk) disable iff (!rst_) $rose(cmdOe) |-> !cmdOut)
        else begin
            $error("cmdOut not low in the first driven cycle");
            assertFailed = 1'b1;
        end

endmodule

/* dv/sdCardTb.sv */
`timescale 1ns/1ps
`include "sdCard_config.svh"

module sdCardTb;
    import sdCardPkg::*;

    // Divisors x^7 + x^3 + 1 and x^16 + x^12 + x^5 + 1 with their top terms
    localparam logic [7:0]  Crc7Divisor  = 8'h89;
    localparam logic [16:0] Crc16Divisor = 17'h1_1021;
    localparam int LineBits    = `SD_BLOCK_NIBBLES + 16;
    localparam int RespWindow  = 64;
    localparam int DataTimeout = 4 * `SD_NAC;

    typedef struct packed {
        logic        respSeen;
        logic [7:0]  respLatency;
        logic        errorSeen;
        logic [7:0]  errorLatency;
        logic        datOeAtStop;
        logic        datOeAfterStop;
        logic [47:0] bits;
    } outcomeT;

    logic       clk;
    logic       rst_;
    logic       cmdIn;
    logic       cmdOut;
    logic       cmdOe;
    logic [3:0] datOut;
    logic       datOe;
    logic       cmdError;

    integer  seed;
    outcomeT res;

    sdCardTop dut0 (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .datOut   (datOut),
        .datOe    (datOe),
        .cmdError (cmdError)
    );

    bind sdCardTop sdCardChecker checker0 (
        .clk      (clk),
        .rst_     (rst_),
        .cmdOut   (cmdOut),
        .cmdOe    (cmdOe),
        .datOe    (datOe),
        .cmdError (cmdError)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ======================================================================
    // Failure reporting and random numbers
    // ======================================================================
    task automatic reportError(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on a timeout");
    endtask

    function automatic int randomBelow(input int limit);
        return $unsigned($random(seed)) % limit;
    endfunction

    // ======================================================================
    // Reference model
    // ======================================================================

    // Remainder of the header times x^7 by long division
    function automatic crc7T crc7Of(input logic [39:0] header);
        logic [46:0] rem;
        rem = {header, 7'b0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ Crc7Divisor;
            end
        end
        return rem[6:0];
    endfunction

    // Line payload with 16 zero bits already appended
    function automatic crc16T crc16Of(input logic [LineBits-1:0] bits);
        logic [LineBits-1:0] rem;
        rem = bits;
        for (int i = LineBits - 1; i >= 16; i--) begin
            if (rem[i]) begin
                rem[i -: 17] = rem[i -: 17] ^ Crc16Divisor;
            end
        end
        return rem[15:0];
    endfunction

    function automatic logic [47:0] commandFrame(input logic [5:0] index,
                                                 input logic [31:0] arg);
        logic [39:0] header;
        header = {2'b01, index, arg};
        return {header, crc7Of(header), 1'b1};
    endfunction

    // ======================================================================
    // Host side of the command line
    // ======================================================================
    task automatic idleCycles(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic sendCommand(input logic [47:0] frame);
        for (int i = 47; i >= 0; i--) begin
            @(posedge clk);
            cmdIn <= frame[i];
        end
        @(posedge clk);
        cmdIn <= 1'b1;
    endtask

    // Counts cycles from the one after the end bit
    task automatic observeCommand(output outcomeT out);
        int n;
        out = '0;
        n = 0;
        while (!out.respSeen && n < RespWindow) begin
            @(negedge clk);
            n++;
            if (cmdError && !out.errorSeen) begin
                out.errorSeen    = 1'b1;
                out.errorLatency = 8'(n);
            end
            if (n == 2) begin
                out.datOeAtStop = datOe;
            end
            if (n == 3) begin
                out.datOeAfterStop = datOe;
            end
            if (cmdOe) begin
                out.respSeen    = 1'b1;
                out.respLatency = 8'(n);
            end
        end
        if (out.respSeen) begin
            out.bits[47] = cmdOut;
            for (int i = 46; i >= 0; i--) begin
                @(negedge clk);
                assert (cmdOe) else reportError("cmdOe dropped inside a response");
                out.bits[i] = cmdOut;
            end
            @(negedge clk);
            assert (!cmdOe) else reportError("cmdOe still high after the end bit");
        end
    endtask

    task automatic runFrame(input logic [47:0] frame);
        idleCycles(1 + randomBelow(8));
        sendCommand(frame);
        observeCommand(res);
    endtask

    task automatic runCommand(input logic [5:0] index, input logic [31:0] arg);
        runFrame(commandFrame(index, arg));
    endtask

    task automatic checkResponse(input outcomeT out, input logic [5:0] index,
                                 input logic [31:0] arg, input logic [31:0] argMask,
                                 input logic noCrc, input string name);
        crc7T expCrc;
        assert (out.respSeen) else reportError({name, ": no response"});
        assert (!out.errorSeen) else reportError({name, ": unexpected cmdError"});
        assert (out.respLatency == `SD_NCR + 2)
            else reportError($sformatf("%s: start bit after %0d cycles, expected %0d",
                                       name, out.respLatency, `SD_NCR + 2));
        assert (out.bits[47:46] == 2'b00) else reportError({name, ": bad preamble"});
        assert (out.bits[45:40] == index)
            else reportError($sformatf("%s: index %0d, expected %0d",
                                       name, out.bits[45:40], index));
        assert ((out.bits[39:8] & argMask) == (arg & argMask))
            else reportError($sformatf("%s: argument %h, expected %h",
                                       name, out.bits[39:8], arg & argMask));
        expCrc = noCrc ? 7'h7F : crc7Of(out.bits[47:8]);
        assert (out.bits[7:1] == expCrc)
            else reportError($sformatf("%s: CRC7 %h, expected %h", name, out.bits[7:1], expCrc));
        assert (out.bits[0]) else reportError({name, ": end bit is 0"});
    endtask

    task automatic checkRejected(input outcomeT out, input string name);
        assert (out.errorSeen && out.errorLatency == 2)
            else reportError({name, ": no cmdError pulse two cycles after the end bit"});
        assert (!out.respSeen) else reportError({name, ": rejected command got a response"});
    endtask

    // ======================================================================
    // Read block checks on the data lines
    // ======================================================================
    task automatic checkBlocks(input int blocks);
        readWordT            word;
        logic [3:0]          nib;
        logic [LineBits-1:0] lineBits [4];
        crc16T               lineCrc [4];
        int                  n;
        word = `SD_FIRST_WORD;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!datOe && n < DataTimeout);
        if (!datOe) begin
            reportTimeout("the first read block");
        end
        assert (n == `SD_NAC + 2)
            else reportError($sformatf("first start bit after %0d cycles", n));
        for (int b = 0; b < blocks; b++) begin
            assert (datOut == 4'h0) else reportError("block start nibble is not zero");
            for (int k = 0; k < `SD_BLOCK_NIBBLES; k++) begin
                @(negedge clk);
                // High nibble of each word goes out first
                nib = 4'(word >> (12 - 4 * (k % 4)));
                if (k % 4 == 3) begin
                    word = word - 1'b1;
                end
                assert (datOe && datOut == nib)
                    else reportError($sformatf("block %0d nibble %0d: got %h, expected %h",
                                               b, k, datOut, nib));
                for (int l = 0; l < 4; l++) begin
                    lineBits[l][LineBits - 1 - k] = nib[l];
                end
            end
            for (int l = 0; l < 4; l++) begin
                lineBits[l][15:0] = '0;
                lineCrc[l]        = crc16Of(lineBits[l]);
            end
            for (int j = 15; j >= 0; j--) begin
                @(negedge clk);
                assert (datOe) else reportError("datOe low inside the CRC16 field");
                for (int l = 0; l < 4; l++) begin
                    assert (datOut[l] == lineCrc[l][j])
                        else reportError($sformatf("block %0d line %0d CRC16 bit %0d wrong",
                                                   b, l, j));
                end
            end
            @(negedge clk);
            assert (datOe && datOut == 4'hF) else reportError("bad block end nibble");
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (!datOe && n < DataTimeout);
            if (!datOe) begin
                reportTimeout("the next read block");
            end
            assert (n == `SD_NAC + 1)
                else reportError($sformatf("block gap of %0d cycles", n - 1));
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        logic [47:0] frame;
        logic [31:0] arg;
        seed  = 32'haa8a3c28;
        rst_  <= 1'b0;
        cmdIn <= 1'b1;
        repeat (16) @(posedge clk);
        rst_ <= 1'b1;
        idleCycles(4);

        // Interface condition echo
        for (int i = 0; i < 4; i++) begin
            arg = $random(seed);
            runCommand(CMD8[5:0], arg);
            checkResponse(res, 6'd8, arg, 32'h0000_0FFF, 1'b0, "CMD8");
        end

        // Address assignment and card select
        runCommand(CMD3[5:0], $random(seed));
        checkResponse(res, 6'd3, {`SD_RCA, `SD_R6_STATUS}, '1, 1'b0, "CMD3");
        runCommand(CMD7[5:0], {`SD_RCA, 16'(randomBelow(65536))});
        checkResponse(res, 6'd7, `SD_CARD_STATUS, '1, 1'b0, "CMD7 own RCA");
        arg = $random(seed);
        if (arg[31:16] == `SD_RCA) begin
            arg[31:16] = ~arg[31:16];
        end
        runCommand(CMD7[5:0], arg);
        checkRejected(res, "CMD7 other RCA");

        // Application command prefix
        runCommand(CMD55[5:0], {`SD_RCA, 16'h0});
        checkResponse(res, 6'd55, `SD_CARD_STATUS, '1, 1'b0, "CMD55");
        runCommand(ACMD41[5:0], $random(seed));
        checkResponse(res, 6'h3F, `SD_OCR_READY, '1, 1'b1, "ACMD41");
        runCommand(ACMD41[5:0], $random(seed));
        checkRejected(res, "code 41 without prefix");

        // Damaged frames
        for (int i = 0; i < 3; i++) begin
            frame = commandFrame(CMD8[5:0], $random(seed));
            frame[1 + randomBelow(7)] ^= 1'b1;
            runFrame(frame);
            checkRejected(res, "corrupted CRC7");
            frame    = commandFrame(CMD8[5:0], $random(seed));
            frame[0] = 1'b0;
            runFrame(frame);
            checkRejected(res, "bad end bit");
        end

        // Multi-block read with response and data overlapping
        idleCycles(1 + randomBelow(8));
        sendCommand(commandFrame(CMD18[5:0], $random(seed)));
        fork
            observeCommand(res);
            checkBlocks(2);
        join
        checkResponse(res, 6'd18, `SD_CARD_STATUS, '1, 1'b0, "CMD18");

        // Stop in mid-block and restart from the first word
        idleCycles(20 + randomBelow(300));
        runCommand(CMD12[5:0], $random(seed));
        checkResponse(res, 6'd12, `SD_CARD_STATUS, '1, 1'b0, "CMD12");
        assert (res.datOeAtStop && !res.datOeAfterStop)
            else reportError("datOe did not drop right after the stop");
        for (int i = 0; i < 2 * `SD_NAC; i++) begin
            @(negedge clk);
            assert (!datOe) else reportError("datOe high after the read stopped");
        end
        idleCycles(1 + randomBelow(8));
        sendCommand(commandFrame(CMD18[5:0], $random(seed)));
        fork
            observeCommand(res);
            checkBlocks(1);
        join
        checkResponse(res, 6'd18, `SD_CARD_STATUS, '1, 1'b0, "second CMD18");
        idleCycles(20 + randomBelow(300));
        runCommand(CMD12[5:0], $random(seed));
        checkResponse(res, 6'd12, `SD_CARD_STATUS, '1, 1'b0, "second CMD12");
        assert (res.datOeAtStop && !res.datOeAfterStop)
            else reportError("datOe did not drop after the second stop");

        // Card reset drops the address
        runCommand(CMD0[5:0], 32'h0);
        assert (!res.respSeen && !res.errorSeen)
            else reportError("CMD0 got a response or an error");
        runCommand(CMD7[5:0], {`SD_RCA, 16'h0});
        checkRejected(res, "CMD7 after CMD0");

        idleCycles(4);
        if (!dut0.checker0.assertFailed) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+source
source/sdCardPkg.sv
source/sdCrc.sv
source/sdPhaseTimer.sv
source/sdCmdReceiver.sv
source/sdCardControl.sv
source/sdRespSender.sv
source/sdDatSender.sv
source/sdCardTop.sv
dv/sdCard_checker.sv
dv/sdCardTb.sv
